// ==== design/matrix_adder_params.svh ====
`ifndef MATRIX_ADDER_PARAMS_SVH
`define MATRIX_ADDER_PARAMS_SVH

// grid side length
`define MAT_DIM 5

// elements in the full grid
`define MAT_ELEMS 25

`define DATA_WIDTH 9
`define DIM_WIDTH 3

`endif

// ==== design/matrix_pkg.sv ====
`default_nettype none

`include "matrix_adder_params.svh"

package matrix_pkg;

    // one matrix element, sums wrap at this width
    typedef logic [`DATA_WIDTH-1:0] elem_t;

    // row and column counts of one operand
    typedef struct packed {
        logic [`DIM_WIDTH-1:0] rows;
        logic [`DIM_WIDTH-1:0] cols;
    } mat_dims_t;

    // one grid row, column 0 in the low bits
    typedef elem_t [`MAT_DIM-1:0] row_t;

    // flat: packed row-major order, element 0 in the low bits
    // grid: padded 5x5 layout, grid[r][c] sits on flat[5*r+c]
    typedef union packed {
        elem_t [`MAT_ELEMS-1:0] flat;
        row_t [`MAT_DIM-1:0] grid;
    } matrix_u;

endpackage

`default_nettype wire

// ==== design/matrix_order.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_adder_params.svh"

module matrix_order
    import matrix_pkg::*;
(
    input wire logic clk,
    input wire logic reset_n,
    input wire logic load,
    input wire mat_dims_t dims,
    input wire matrix_u data_in,
    output matrix_u grid_out
);

    matrix_u mapped;

    // packed element k lands on row k / cols, column k mod cols
    always_comb begin : map_to_grid
        int k;

        mapped = '0;
        for (int r = 0; r < `MAT_DIM; r++) begin
            for (int c = 0; c < `MAT_DIM; c++) begin
                k = r * int'(dims.cols) + c;
                // everything outside rows x cols stays zero
                if (r < int'(dims.rows) && c < int'(dims.cols) && k < `MAT_ELEMS) begin
                    mapped.grid[r][c] = data_in.flat[k];
                end
            end
        end
    end

    // captured once per operation, engine reads it row by row
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid_out <= '0;
        end else if (load) begin
            grid_out <= mapped;
        end
    end

endmodule

`default_nettype wire

// ==== design/row_add_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_adder_params.svh"

module row_add_engine
    import matrix_pkg::*;
(
    input wire logic clk,
    input wire logic reset_n,
    input wire logic en,
    input wire mat_dims_t dims_a,
    input wire mat_dims_t dims_b,
    input wire matrix_u grid_a,
    input wire matrix_u grid_b,
    output logic load,
    output logic restore,
    output logic clear,
    output matrix_u sum,
    output mat_dims_t dims,
    output logic busy,
    output logic is_valid
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_CHECK = 3'd1;
    localparam logic [2:0] ST_ADD = 3'd2;
    localparam logic [2:0] ST_RESTORE = 3'd3;
    localparam logic [2:0] ST_HOLD = 3'd4;

    logic [2:0] state;
    logic [`DIM_WIDTH-1:0] row_cnt;
    mat_dims_t dims_a_q;
    mat_dims_t dims_b_q;
    logic dims_ok;
    logic add_en;
    row_t row_a;
    row_t row_b;
    row_t row_sum;

    // shapes must match and lie in 1..5
    assign dims_ok = (dims_a_q == dims_b_q)
                  && (dims_a_q.rows != '0) && (dims_a_q.rows <= `MAT_DIM)
                  && (dims_a_q.cols != '0) && (dims_a_q.cols <= `MAT_DIM);

    assign load = (state == ST_IDLE) && en;
    assign restore = (state == ST_RESTORE);
    assign clear = (state == ST_HOLD) && !en;
    assign busy = (state == ST_CHECK) || (state == ST_ADD) || (state == ST_RESTORE);
    assign dims = dims_a_q;

    // row 0 is added in the check cycle when the shapes pass
    assign add_en = ((state == ST_CHECK) && dims_ok) || (state == ST_ADD);

    // five parallel adders on the selected row
    always_comb begin
        row_a = grid_a.grid[row_cnt];
        row_b = grid_b.grid[row_cnt];
        for (int c = 0; c < `MAT_DIM; c++) begin
            row_sum[c] = row_a[c] + row_b[c];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
            row_cnt <= '0;
            is_valid <= 1'b1;
            dims_a_q <= '0;
            dims_b_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (en) begin
                        state <= ST_CHECK;
                        row_cnt <= '0;
                        dims_a_q <= dims_a;
                        dims_b_q <= dims_b;
                    end
                end
                ST_CHECK: begin
                    if (dims_ok) begin
                        state <= ST_ADD;
                        row_cnt <= row_cnt + 1'b1;
                    end else begin
                        state <= ST_HOLD;
                        is_valid <= 1'b0;
                    end
                end
                ST_ADD: begin
                    if (row_cnt == `DIM_WIDTH'(`MAT_DIM - 1)) begin
                        state <= ST_RESTORE;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                ST_RESTORE: begin
                    state <= ST_HOLD;
                end
                ST_HOLD: begin
                    // wait for en to drop, then start over
                    if (!en) begin
                        state <= ST_IDLE;
                        is_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // every row is rewritten before restore reads it
    always_ff @(posedge clk) begin
        if (add_en) begin
            sum.grid[row_cnt] <= row_sum;
        end
    end

endmodule

`default_nettype wire

// ==== design/matrix_restore.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_adder_params.svh"

module matrix_restore
    import matrix_pkg::*;
(
    input wire logic clk,
    input wire logic reset_n,
    input wire logic restore,
    input wire logic clear,
    input wire mat_dims_t dims,
    input wire matrix_u sum,
    output mat_dims_t dims_out,
    output matrix_u data_out
);

    matrix_u unpacked;

    // inverse of the order mapping, grid[r][c] goes back to r*cols+c
    always_comb begin : map_to_flat
        int k;

        unpacked = '0;
        for (int r = 0; r < `MAT_DIM; r++) begin
            for (int c = 0; c < `MAT_DIM; c++) begin
                k = r * int'(dims.cols) + c;
                if (r < int'(dims.rows) && c < int'(dims.cols) && k < `MAT_ELEMS) begin
                    unpacked.flat[k] = sum.grid[r][c];
                end
            end
        end
    end

    // result is held until the engine asks for a clear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dims_out <= '0;
            data_out <= '0;
        end else if (clear) begin
            dims_out <= '0;
            data_out <= '0;
        end else if (restore) begin
            dims_out <= dims;
            data_out <= unpacked;
        end
    end

endmodule

`default_nettype wire

// ==== design/matrix_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module matrix_adder
    import matrix_pkg::*;
(
    input wire logic clk,
    input wire logic reset_n,
    input wire mat_dims_t dims_a,
    input wire mat_dims_t dims_b,
    input wire matrix_u data_a,
    input wire matrix_u data_b,
    input wire logic en,
    output mat_dims_t dims_out,
    output matrix_u data_out,
    output logic is_valid,
    output logic busy
);

    logic load;
    logic restore;
    logic clear;
    matrix_u grid_a;
    matrix_u grid_b;
    matrix_u sum;
    mat_dims_t sum_dims;

    // operand a into the padded grid
    matrix_order order_a (
        .clk      (clk),
        .reset_n  (reset_n),
        .load     (load),
        .dims     (dims_a),
        .data_in  (data_a),
        .grid_out (grid_a)
    );

    // operand b into the padded grid
    matrix_order order_b (
        .clk      (clk),
        .reset_n  (reset_n),
        .load     (load),
        .dims     (dims_b),
        .data_in  (data_b),
        .grid_out (grid_b)
    );

    row_add_engine engine (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .dims_a   (dims_a),
        .dims_b   (dims_b),
        .grid_a   (grid_a),
        .grid_b   (grid_b),
        .load     (load),
        .restore  (restore),
        .clear    (clear),
        .sum      (sum),
        .dims     (sum_dims),
        .busy     (busy),
        .is_valid (is_valid)
    );

    // sum grid back to packed order
    matrix_restore restorer (
        .clk      (clk),
        .reset_n  (reset_n),
        .restore  (restore),
        .clear    (clear),
        .dims     (sum_dims),
        .sum      (sum),
        .dims_out (dims_out),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for 8 cycles, released on a rising edge
    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/matrix_adder_cases.svh ====
`ifndef MATRIX_ADDER_CASES_SVH
`define MATRIX_ADDER_CASES_SVH

localparam int NUM_CASES = 11;

typedef struct packed {
    mat_dims_t dims_a;
    mat_dims_t dims_b;
    logic [7:0] seed_ofs;
    logic exp_valid;
    logic tail;
} case_t;

// columns: dims_a {rows, cols}, dims_b {rows, cols}, seed offset,
// expected is_valid, nonzero tail past rows x cols
localparam case_t CASES [NUM_CASES] = '{
    // full grid
    '{'{3'd5, 3'd5}, '{3'd5, 3'd5}, 8'h00, 1'b1, 1'b0},
    // smaller shapes with random tails
    '{'{3'd2, 3'd3}, '{3'd2, 3'd3}, 8'h11, 1'b1, 1'b1},
    '{'{3'd1, 3'd5}, '{3'd1, 3'd5}, 8'h22, 1'b1, 1'b1},
    '{'{3'd5, 3'd1}, '{3'd5, 3'd1}, 8'h33, 1'b1, 1'b1},
    '{'{3'd3, 3'd3}, '{3'd3, 3'd3}, 8'h44, 1'b1, 1'b1},
    // mismatched shapes
    '{'{3'd2, 3'd3}, '{3'd3, 3'd2}, 8'h55, 1'b0, 1'b1},
    // out of range, zero and six
    '{'{3'd0, 3'd3}, '{3'd0, 3'd3}, 8'h66, 1'b0, 1'b1},
    '{'{3'd6, 3'd2}, '{3'd6, 3'd2}, 8'h77, 1'b0, 1'b1},
    '{'{3'd4, 3'd6}, '{3'd4, 3'd6}, 8'h88, 1'b0, 1'b0},
    // normal runs after an invalid one
    '{'{3'd5, 3'd5}, '{3'd5, 3'd5}, 8'h99, 1'b1, 1'b1},
    '{'{3'd4, 3'd2}, '{3'd4, 3'd2}, 8'haa, 1'b1, 1'b0}
};

`endif

// ==== test/matrix_adder_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matrix_adder_params.svh"

module matrix_adder_tb
    import matrix_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 50;
    localparam int CHECK_W = $bits(matrix_u);
    localparam int FULL_BUSY = 6;
    localparam logic [31:0] BASE_SEED = 32'h589b_cc08;

    `include "matrix_adder_cases.svh"

    logic clk;
    logic reset_n;
    mat_dims_t dims_a;
    mat_dims_t dims_b;
    matrix_u data_a;
    matrix_u data_b;
    logic en;
    mat_dims_t dims_out;
    matrix_u data_out;
    logic is_valid;
    logic busy;

    integer seed;

    clock_gen clocks (
        .clk     (clk),
        .reset_n (reset_n)
    );

    matrix_adder UUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .dims_a   (dims_a),
        .dims_b   (dims_b),
        .data_a   (data_a),
        .data_b   (data_b),
        .en       (en),
        .dims_out (dims_out),
        .data_out (data_out),
        .is_valid (is_valid),
        .busy     (busy)
    );

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [CHECK_W-1:0] actual,
                               input logic [CHECK_W-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    // random operand with elements past rows x cols zeroed unless tail is set
    function automatic matrix_u random_matrix(input mat_dims_t d, input logic tail);
        matrix_u m;
        int n;

        n = int'(d.rows) * int'(d.cols);
        for (int k = 0; k < `MAT_ELEMS; k++) begin
            m.flat[k] = elem_t'($random(seed));
            if (k >= n && !tail) begin
                m.flat[k] = '0;
            end
        end
        return m;
    endfunction

    // element-wise sum modulo 512 with zero from rows x cols on
    function automatic matrix_u expected_sum(input matrix_u a, input matrix_u b,
                                             input mat_dims_t d);
        matrix_u s;
        int n;
        int v;

        s = '0;
        n = int'(d.rows) * int'(d.cols);
        for (int k = 0; k < n; k++) begin
            v = (int'(a.flat[k]) + int'(b.flat[k])) % (1 << `DATA_WIDTH);
            s.flat[k] = elem_t'(v);
        end
        return s;
    endfunction

    task automatic wait_for_busy(input int idx);
        int cycles;

        cycles = 0;
        @(negedge clk);
        while (busy !== 1'b1) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: busy never rose in case %0d", idx);
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // returns at the first sample with busy low
    task automatic count_busy(input int idx, output int cycles);
        cycles = 1;
        @(negedge clk);
        while (busy === 1'b1) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: busy stuck high in case %0d", idx);
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // edges from en low until is_valid and dims_out are back at rest
    task automatic wait_for_clear(input int idx, output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!(is_valid === 1'b1 && dims_out === '0)) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: outputs never cleared after en fell in case %0d", idx);
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    initial begin
        int cycles;
        int busy_cycles;
        int clear_cycles;
        case_t tc;
        matrix_u op_a;
        matrix_u op_b;
        matrix_u exp_data;
        mat_dims_t exp_dims;

        dims_a = '0;
        dims_b = '0;
        data_a = '0;
        data_b = '0;
        en = 1'b0;
        seed = BASE_SEED;

        cycles = 0;
        while (reset_n !== 1'b1) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: reset was never released");
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
        check_value("busy", CHECK_W'(busy), CHECK_W'(1'b0));
        check_value("is_valid", CHECK_W'(is_valid), CHECK_W'(1'b1));
        check_value("data_out", CHECK_W'(data_out), CHECK_W'(0));
        check_value("dims_out", CHECK_W'(dims_out), CHECK_W'(0));

        for (int i = 0; i < NUM_CASES; i++) begin
            tc = CASES[i];
            seed = BASE_SEED + 32'(tc.seed_ofs);
            op_a = random_matrix(tc.dims_a, tc.tail);
            op_b = random_matrix(tc.dims_b, tc.tail);
            if (tc.exp_valid) begin
                exp_data = expected_sum(op_a, op_b, tc.dims_a);
                exp_dims = tc.dims_a;
            end else begin
                exp_data = '0;
                exp_dims = '0;
            end

            @(posedge clk);
            dims_a <= tc.dims_a;
            dims_b <= tc.dims_b;
            data_a <= op_a;
            data_b <= op_b;
            en <= 1'b1;

            wait_for_busy(i);
            count_busy(i, busy_cycles);
            check_value("busy_cycles", CHECK_W'(busy_cycles),
                        CHECK_W'(tc.exp_valid ? FULL_BUSY : 1));
            check_value("is_valid", CHECK_W'(is_valid), CHECK_W'(tc.exp_valid));
            check_value("dims_out", CHECK_W'(dims_out), CHECK_W'(exp_dims));
            check_value("data_out", CHECK_W'(data_out), CHECK_W'(exp_data));

            // result must hold while en stays high
            repeat (3) @(negedge clk);
            check_value("busy", CHECK_W'(busy), CHECK_W'(1'b0));
            check_value("data_out", CHECK_W'(data_out), CHECK_W'(exp_data));

            // the engine clears on the first edge that samples en low
            @(posedge clk);
            en <= 1'b0;
            wait_for_clear(i, clear_cycles);
            check_value("clear_cycles", CHECK_W'(clear_cycles), CHECK_W'(1));
            check_value("data_out", CHECK_W'(data_out), CHECK_W'(0));
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== matrix_adder.f ====
+incdir+design
+incdir+test
design/matrix_pkg.sv
design/matrix_order.sv
design/row_add_engine.sv
design/matrix_restore.sv
design/matrix_adder.sv
test/clock_gen.sv
test/matrix_adder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module matrix_adder_tb \
    -Mdir obj_dir \
    -f matrix_adder.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vmatrix_adder_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if echo "$sim_output" | grep -q -x -F "Result: PASSED"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
